//--- Bender.yml
package:
  name: axi_noc_chimney

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - verilog/axi_chan_pkg.sv
      - verilog/flit_pkg.sv
      - verilog/addr_route_map.sv
      - verilog/req_flit_packer.sv
      - verilog/flit_fifo.sv
      - verilog/rsp_flit_unpacker.sv
      - verilog/axi_noc_chimney.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/tb_axi_noc_chimney.sv

//--- build.f
+incdir+include
verilog/axi_chan_pkg.sv
verilog/flit_pkg.sv
verilog/addr_route_map.sv
verilog/req_flit_packer.sv
verilog/flit_fifo.sv
verilog/rsp_flit_unpacker.sv
verilog/axi_noc_chimney.sv
tests/tb_axi_noc_chimney.sv

//--- include/noc_cfg.svh
//////////////////////////////////////////////////
// Configuration macros for the network interface
// AXI and flit widths, request FIFO depth and the
// system address map rules
//////////////////////////////////////////////////

`ifndef NOC_CFG_SVH
`define NOC_CFG_SVH

`define NOC_ADDR_WIDTH     16
`define NOC_DATA_WIDTH     32
`define NOC_AXI_ID_WIDTH   4
`define NOC_LEN_WIDTH      8
`define NOC_NODE_ID_WIDTH  4
`define NOC_FIFO_DEPTH     4

// Address map rules with inclusive start and exclusive end
`define NOC_NUM_SAM_RULES  3
`define NOC_SAM_START_0    16'h0000
`define NOC_SAM_END_0      16'h4000
`define NOC_SAM_NODE_0     4'd1
`define NOC_SAM_START_1    16'h4000
`define NOC_SAM_END_1      16'h8000
`define NOC_SAM_NODE_1     4'd2
`define NOC_SAM_START_2    16'h8000
`define NOC_SAM_END_2      16'hC000
`define NOC_SAM_NODE_2     4'd5
`define NOC_SAM_DEFAULT_NODE 4'd15

`endif

//--- tests/tb_axi_noc_chimney.sv
//////////////////////////////////////////////////
// Testbench for the AXI to NoC network interface
// Stimulus table, reference model for request
// flits, flit monitor, response checks, watchdog
//////////////////////////////////////////////////

`timescale 1ns/1ns

`include "noc_cfg.svh"

module tb_axi_noc_chimney
  import axi_chan_pkg::*;
  import flit_pkg::*;
();

  localparam int CLK_PERIOD  = 8;
  localparam int WD_MARGIN   = 25;
  localparam int DRAIN_LIMIT = 300;
  localparam node_id_t TILE_ID = 4'd3;

  typedef enum logic [2:0] {OP_WRITE, OP_READ, OP_WR_RD, OP_RSP_B, OP_RSP_R} op_e;

  // Response rows use len as the number of stall cycles
  typedef struct packed {
    op_e         op;
    axi_addr_t   addr;
    axi_len_t    len;
    axi_id_t     id;
    logic [15:0] rdy_pat;
  } test_row_t;

  localparam int NUM_TESTS = 11;
  localparam test_row_t TESTS [NUM_TESTS] = '{
    '{OP_WRITE, 16'h1200, 8'd3, 4'h2, 16'hFFFF},
    '{OP_READ,  16'h5000, 8'd0, 4'h7, 16'hFFFF},
    '{OP_WRITE, 16'hD000, 8'd1, 4'h4, 16'hFFFF},
    '{OP_READ,  16'hF004, 8'd2, 4'h1, 16'hFFFF},
    '{OP_WR_RD, 16'h8100, 8'd5, 4'h9, 16'hFFFF},
    '{OP_WR_RD, 16'h3000, 8'd2, 4'h3, 16'hFFFF},
    '{OP_WRITE, 16'h4400, 8'd7, 4'h5, 16'h000F},
    '{OP_WR_RD, 16'hA000, 8'd3, 4'h6, 16'h0101},
    '{OP_RSP_B, 16'h0000, 8'd2, 4'hB, 16'hFFFF},
    '{OP_RSP_R, 16'h0000, 8'd3, 4'hC, 16'hFFFF},
    '{OP_RSP_R, 16'h0000, 8'd0, 4'h1, 16'hFFFF}
  };

  logic         clk = 1'b0;
  logic         rst_n_i;
  node_id_t     id_i;
  axi_ax_chan_t aw_i, ar_i;
  axi_w_chan_t  w_i;
  axi_b_chan_t  b_o;
  axi_r_chan_t  r_o;
  logic         aw_valid_i, aw_ready_o, w_valid_i, w_ready_o, ar_valid_i, ar_ready_o;
  logic         b_valid_o, b_ready_i, r_valid_o, r_ready_i;
  flit_t        req_flit_o, rsp_flit_i;
  logic         req_valid_o, req_ready_i, rsp_valid_i, rsp_ready_o;

  integer       seed;
  int           errors = 0;
  int           checks = 0;
  logic [15:0]  cur_pat = 16'hFFFF;
  logic [3:0]   pat_idx = '0;
  logic         in_burst = 1'b0;
  flit_t        wr_q [$];
  flit_t        rd_q [$];

  axi_noc_chimney DUT (
    .clk_i ( clk ), .rst_n_i, .id_i,
    .aw_i, .aw_valid_i, .aw_ready_o, .w_i, .w_valid_i, .w_ready_o,
    .ar_i, .ar_valid_i, .ar_ready_o, .b_o, .b_valid_o, .b_ready_i,
    .r_o, .r_valid_o, .r_ready_i, .req_flit_o, .req_valid_o, .req_ready_i,
    .rsp_flit_i, .rsp_valid_i, .rsp_ready_o
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // Request link ready follows the pattern of the current row
  always @(negedge clk) begin
    req_ready_i = cur_pat[pat_idx];
    pat_idx     = pat_idx + 1'b1;
  end

  //////////////////////////////////////////////////
  // Reference model and checks
  //////////////////////////////////////////////////

  function automatic node_id_t lookup_node(input axi_addr_t addr);
    if (addr >= `NOC_SAM_START_0 && addr < `NOC_SAM_END_0) return `NOC_SAM_NODE_0;
    if (addr >= `NOC_SAM_START_1 && addr < `NOC_SAM_END_1) return `NOC_SAM_NODE_1;
    if (addr >= `NOC_SAM_START_2 && addr < `NOC_SAM_END_2) return `NOC_SAM_NODE_2;
    return `NOC_SAM_DEFAULT_NODE;
  endfunction

  function automatic flit_t make_flit(input axi_ch_e ch, input node_id_t dst,
                                      input logic last, input flit_payload_t payload);
    flit_t f;
    f.hdr.dst_id = dst;
    f.hdr.src_id = TILE_ID;
    f.hdr.axi_ch = ch;
    f.hdr.last   = last;
    f.payload    = payload;
    return f;
  endfunction

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    checks++;
    assert (actual === expected) else begin
      errors++;
      $display("Fail at %0t ns: %s expected %h, actual %h", $time, name, expected, actual);
    end
  endtask

  // Writes and reads have separate queues because only the burst lock orders them
  task automatic check_flit(input flit_t f);
    logic is_wr;
    is_wr = (f.hdr.axi_ch == AXI_AW) || (f.hdr.axi_ch == AXI_W);
    checks++;
    assert (!in_burst || f.hdr.axi_ch == AXI_W) else begin
      errors++;
      $display("Error at %0t ns: a non-W flit cut into a write burst", $time);
    end
    checks++;
    assert ((is_wr && wr_q.size() > 0) || (!is_wr && rd_q.size() > 0)) else begin
      errors++;
      $display("Error at %0t ns: a flit left the link that was not expected", $time);
    end
    if (is_wr && wr_q.size() > 0) begin
      check_value("req_flit_o", wr_q.pop_front(), f);
    end else if (!is_wr && rd_q.size() > 0) begin
      check_value("req_flit_o", rd_q.pop_front(), f);
    end
    if (f.hdr.axi_ch == AXI_AW) begin
      in_burst = 1'b1;
    end else if (f.hdr.axi_ch == AXI_W && f.hdr.last) begin
      in_burst = 1'b0;
    end
  endtask

  always @(posedge clk) begin
    if (rst_n_i && req_valid_o && req_ready_i) begin
      check_flit(req_flit_o);
    end
  end

  //////////////////////////////////////////////////
  // Drivers
  //////////////////////////////////////////////////

  task automatic drive_write(input axi_addr_t addr, input axi_len_t len, input axi_id_t id);
    axi_ax_chan_t aw;
    axi_w_chan_t  beats [$];
    axi_w_chan_t  w;
    node_id_t     dst;
    aw  = '{id: id, addr: addr, len: len};
    dst = lookup_node(addr);
    wr_q.push_back(make_flit(AXI_AW, dst, 1'b0, flit_payload_t'(aw)));
    for (int i = 0; i <= len; i++) begin
      w.data = $random(seed);
      w.last = (i == len);
      beats.push_back(w);
      wr_q.push_back(make_flit(AXI_W, dst, w.last, flit_payload_t'(w)));
    end
    @(negedge clk);
    aw_i       = aw;
    aw_valid_i = 1'b1;
    @(posedge clk);
    while (!aw_ready_o) @(posedge clk);
    @(negedge clk);
    aw_valid_i = 1'b0;
    foreach (beats[i]) begin
      w_i       = beats[i];
      w_valid_i = 1'b1;
      @(posedge clk);
      while (!w_ready_o) @(posedge clk);
      @(negedge clk);
    end
    w_valid_i = 1'b0;
  endtask

  task automatic drive_read(input axi_addr_t addr, input axi_len_t len, input axi_id_t id);
    axi_ax_chan_t ar;
    ar = '{id: id, addr: addr, len: len};
    rd_q.push_back(make_flit(AXI_AR, lookup_node(addr), 1'b1, flit_payload_t'(ar)));
    @(negedge clk);
    ar_i       = ar;
    ar_valid_i = 1'b1;
    @(posedge clk);
    while (!ar_ready_o) @(posedge clk);
    @(negedge clk);
    ar_valid_i = 1'b0;
  endtask

  // Stalls the selected ready while the other one is high and then lets the flit through
  task automatic drive_response(input logic is_r, input axi_id_t id, input int stall);
    axi_b_chan_t b;
    axi_r_chan_t r;
    b.id   = id;
    b.resp = axi_resp_t'($random(seed));
    r.id   = id;
    r.data = $random(seed);
    r.resp = axi_resp_t'($random(seed));
    r.last = 1'b1;
    @(negedge clk);
    rsp_flit_i = make_flit(is_r ? AXI_R : AXI_B, TILE_ID, 1'b1,
                           is_r ? flit_payload_t'(r) : flit_payload_t'(b));
    rsp_valid_i = 1'b1;
    b_ready_i   = is_r;
    r_ready_i   = !is_r;
    for (int i = 0; i <= stall; i++) begin
      if (i == stall) begin
        b_ready_i = !is_r;
        r_ready_i = is_r;
      end
      @(posedge clk);
      check_value("rsp_ready_o", (i == stall), rsp_ready_o);
      check_value("b_valid_o", !is_r, b_valid_o);
      check_value("r_valid_o", is_r, r_valid_o);
      if (is_r) begin
        check_value("r_o", r, r_o);
      end else begin
        check_value("b_o", b, b_o);
      end
      @(negedge clk);
    end
    rsp_valid_i = 1'b0;
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    @(negedge clk);
    while ((wr_q.size() != 0 || rd_q.size() != 0) && n < DRAIN_LIMIT) begin
      @(negedge clk);
      n++;
    end
    checks++;
    assert (wr_q.size() == 0 && rd_q.size() == 0) else begin
      errors++;
      $display("Error: %0d request flits never left the link", wr_q.size() + rd_q.size());
    end
  endtask

  //////////////////////////////////////////////////
  // Main sequence and watchdog
  //////////////////////////////////////////////////

  initial begin
    int  err_before;
    op_e op;
    seed = 32'h60ff;
    rst_n_i = 1'b0;
    id_i = TILE_ID;
    aw_i = '0;
    w_i = '0;
    ar_i = '0;
    aw_valid_i = 1'b0;
    w_valid_i = 1'b0;
    ar_valid_i = 1'b0;
    b_ready_i = 1'b1;
    r_ready_i = 1'b1;
    req_ready_i = 1'b1;
    rsp_flit_i = '0;
    rsp_valid_i = 1'b0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n_i = 1'b1;
    @(posedge clk);
    check_value("req_valid_o", 1'b0, req_valid_o);
    check_value("b_valid_o", 1'b0, b_valid_o);
    check_value("r_valid_o", 1'b0, r_valid_o);
    for (int t = 0; t < NUM_TESTS; t++) begin
      err_before = errors;
      op         = TESTS[t].op;
      cur_pat    = TESTS[t].rdy_pat;
      pat_idx    = '0;
      case (op)
        OP_WRITE: drive_write(TESTS[t].addr, TESTS[t].len, TESTS[t].id);
        OP_READ:  drive_read(TESTS[t].addr, TESTS[t].len, TESTS[t].id);
        OP_WR_RD: begin
          fork
            drive_write(TESTS[t].addr, TESTS[t].len, TESTS[t].id);
            drive_read(TESTS[t].addr ^ 16'h4000, TESTS[t].len, TESTS[t].id + 1'b1);
          join
        end
        OP_RSP_B: drive_response(1'b0, TESTS[t].id, TESTS[t].len);
        default:  drive_response(1'b1, TESTS[t].id, TESTS[t].len);
      endcase
      wait_drain();
      $display("Test %0d %s finished with %0d errors", t, op.name(), errors - err_before);
      @(posedge clk);
    end
    $display("Tests: %0d, checks: %0d, errors: %0d", NUM_TESTS, checks, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  // Limit grows with the number of beats in the table
  initial begin
    longint limit;
    int     beats;
    beats = 0;
    for (int t = 0; t < NUM_TESTS; t++) begin
      beats += TESTS[t].len + 3;
    end
    limit = longint'(beats * WD_MARGIN + 20) * CLK_PERIOD;
    #(limit);
    $display("Timeout: the run did not finish within %0d ns", limit);
    $display("Testbench failed");
    $finish;
  end

endmodule

//--- verilog/addr_route_map.sv
//////////////////////////////////////////////////
// System address map lookup
// Address in, destination node ID out
//////////////////////////////////////////////////

`timescale 1ns/1ns

`include "noc_cfg.svh"

module addr_route_map
  import axi_chan_pkg::*;
  import flit_pkg::*;
(
  input  axi_addr_t addr_i,
  output node_id_t  dst_id_o
);

  localparam int unsigned NUM_RULES = `NOC_NUM_SAM_RULES;

  // Rule tables built from the config header
  localparam axi_addr_t RULE_START [NUM_RULES] = '{
    `NOC_SAM_START_0, `NOC_SAM_START_1, `NOC_SAM_START_2
  };
  localparam axi_addr_t RULE_END [NUM_RULES] = '{
    `NOC_SAM_END_0, `NOC_SAM_END_1, `NOC_SAM_END_2
  };
  localparam node_id_t RULE_NODE [NUM_RULES] = '{
    `NOC_SAM_NODE_0, `NOC_SAM_NODE_1, `NOC_SAM_NODE_2
  };

  always_comb begin
    dst_id_o = node_id_t'(`NOC_SAM_DEFAULT_NODE);
    // Walk from the highest rule down so the lowest match is applied last
    for (int i = NUM_RULES - 1; i >= 0; i--) begin
      if ((addr_i >= RULE_START[i]) && (addr_i < RULE_END[i])) begin
        dst_id_o = RULE_NODE[i];
      end
    end
  end

endmodule

//--- verilog/axi_chan_pkg.sv
//////////////////////////////////////////////////
// AXI channel types
// Vector types for the fields and packed structs
// for the AW/AR, W, B and R channels
//////////////////////////////////////////////////

`include "noc_cfg.svh"

package axi_chan_pkg;

  typedef logic [`NOC_ADDR_WIDTH-1:0]   axi_addr_t;
  typedef logic [`NOC_DATA_WIDTH-1:0]   axi_data_t;
  typedef logic [`NOC_AXI_ID_WIDTH-1:0] axi_id_t;
  typedef logic [`NOC_LEN_WIDTH-1:0]    axi_len_t;
  typedef logic [1:0]                   axi_resp_t;

  // Shared by AW and AR
  typedef struct packed {
    axi_id_t   id;
    axi_addr_t addr;
    axi_len_t  len;
  } axi_ax_chan_t;

  typedef struct packed {
    axi_data_t data;
    logic      last;
  } axi_w_chan_t;

  typedef struct packed {
    axi_id_t   id;
    axi_resp_t resp;
  } axi_b_chan_t;

  typedef struct packed {
    axi_id_t   id;
    axi_data_t data;
    axi_resp_t resp;
    logic      last;
  } axi_r_chan_t;

endpackage

//--- verilog/axi_noc_chimney.sv
//////////////////////////////////////////////////
// Manager-side AXI to NoC network interface
// Request packer and FIFO, response unpacker
//////////////////////////////////////////////////

`timescale 1ns/1ns

`include "noc_cfg.svh"

module axi_noc_chimney
  import axi_chan_pkg::*;
  import flit_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_n_i,
  input  node_id_t     id_i,
  // AXI manager port
  input  axi_ax_chan_t aw_i,
  input  logic         aw_valid_i,
  output logic         aw_ready_o,
  input  axi_w_chan_t  w_i,
  input  logic         w_valid_i,
  output logic         w_ready_o,
  input  axi_ax_chan_t ar_i,
  input  logic         ar_valid_i,
  output logic         ar_ready_o,
  output axi_b_chan_t  b_o,
  output logic         b_valid_o,
  input  logic         b_ready_i,
  output axi_r_chan_t  r_o,
  output logic         r_valid_o,
  input  logic         r_ready_i,
  // NoC links
  output flit_t        req_flit_o,
  output logic         req_valid_o,
  input  logic         req_ready_i,
  input  flit_t        rsp_flit_i,
  input  logic         rsp_valid_i,
  output logic         rsp_ready_o
);

  flit_t pack_flit;
  logic  pack_valid, pack_ready;

  req_flit_packer i_packer (
    .clk_i, .rst_n_i, .id_i,
    .aw_i, .aw_valid_i, .aw_ready_o,
    .w_i, .w_valid_i, .w_ready_o,
    .ar_i, .ar_valid_i, .ar_ready_o,
    .flit_o       ( pack_flit  ),
    .flit_valid_o ( pack_valid ),
    .flit_ready_i ( pack_ready )
  );

  flit_fifo #(
    .DEPTH ( `NOC_FIFO_DEPTH )
  ) i_req_fifo (
    .clk_i, .rst_n_i,
    .data_i  ( pack_flit   ),
    .valid_i ( pack_valid  ),
    .ready_o ( pack_ready  ),
    .data_o  ( req_flit_o  ),
    .valid_o ( req_valid_o ),
    .ready_i ( req_ready_i )
  );

  rsp_flit_unpacker i_unpacker (
    .flit_i       ( rsp_flit_i  ),
    .flit_valid_i ( rsp_valid_i ),
    .flit_ready_o ( rsp_ready_o ),
    .b_o, .b_valid_o, .b_ready_i,
    .r_o, .r_valid_o, .r_ready_i
  );

endmodule

//--- verilog/flit_fifo.sv
//////////////////////////////////////////////////
// Request flit FIFO
// Circular buffer with valid/ready on both sides
//////////////////////////////////////////////////

`timescale 1ns/1ns

module flit_fifo
  import flit_pkg::*;
#(
  parameter int unsigned DEPTH = 4
) (
  input  logic  clk_i,
  input  logic  rst_n_i,
  input  flit_t data_i,
  input  logic  valid_i,
  output logic  ready_o,
  output flit_t data_o,
  output logic  valid_o,
  input  logic  ready_i
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  flit_t            mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             push, pop;

  assign ready_o = (count_q != CNT_W'(DEPTH));
  assign valid_o = (count_q != '0);
  assign data_o  = mem[rd_ptr_q];

  assign push = valid_i && ready_o;
  assign pop  = valid_o && ready_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // Push and pop together leave the fill level unchanged
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem[wr_ptr_q] <= data_i;
    end
  end

endmodule

//--- verilog/flit_pkg.sv
//////////////////////////////////////////////////
// Flit types
// Node ID, channel encoding, flit header and the
// full flit carried on both links
//////////////////////////////////////////////////

`include "noc_cfg.svh"

package flit_pkg;

  import axi_chan_pkg::*;

  typedef logic [`NOC_NODE_ID_WIDTH-1:0] node_id_t;

  // AXI channel carried by a flit
  typedef enum logic [2:0] {
    AXI_AW = 3'd0,
    AXI_W  = 3'd1,
    AXI_AR = 3'd2,
    AXI_B  = 3'd3,
    AXI_R  = 3'd4
  } axi_ch_e;

  typedef struct packed {
    node_id_t dst_id;
    node_id_t src_id;
    axi_ch_e  axi_ch;
    logic     last;
  } flit_hdr_t;

  // R is the widest channel, others sit right-aligned with zero fill
  typedef logic [$bits(axi_r_chan_t)-1:0] flit_payload_t;

  typedef struct packed {
    flit_hdr_t     hdr;
    flit_payload_t payload;
  } flit_t;

endpackage

//--- verilog/req_flit_packer.sv
//////////////////////////////////////////////////
// Request flit packer
// Packs AW, W and AR into request flits, with a
// round-robin choice and a write-burst lock
//////////////////////////////////////////////////

`timescale 1ns/1ns

module req_flit_packer
  import axi_chan_pkg::*;
  import flit_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_n_i,
  input  node_id_t     id_i,
  input  axi_ax_chan_t aw_i,
  input  logic         aw_valid_i,
  output logic         aw_ready_o,
  input  axi_w_chan_t  w_i,
  input  logic         w_valid_i,
  output logic         w_ready_o,
  input  axi_ax_chan_t ar_i,
  input  logic         ar_valid_i,
  output logic         ar_ready_o,
  output flit_t        flit_o,
  output logic         flit_valid_o,
  input  logic         flit_ready_i
);

  // Write path owns the link from AW until W last
  typedef enum logic {
    SEND_AW,
    SEND_W
  } wr_state_e;

  wr_state_e state_q, state_d;
  node_id_t  aw_dst, ar_dst, aw_dst_q;
  logic      rd_pick, rd_sel, rd_sel_q;
  logic      hold_q, rd_prio_q;
  logic      aw_hs, w_hs, ar_hs;

  addr_route_map i_aw_route (
    .addr_i   ( aw_i.addr ),
    .dst_id_o ( aw_dst    )
  );

  addr_route_map i_ar_route (
    .addr_i   ( ar_i.addr ),
    .dst_id_o ( ar_dst    )
  );

  //////////////////////////////////////////////////
  // Arbitration
  //////////////////////////////////////////////////

  // Round robin only matters when both AW and AR are offered
  assign rd_pick = ar_valid_i && (!aw_valid_i || rd_prio_q);
  // A stalled choice is kept so the offered flit stays stable
  assign rd_sel  = hold_q ? rd_sel_q : rd_pick;

  assign flit_valid_o = (state_q == SEND_W) ? w_valid_i : (aw_valid_i || ar_valid_i);

  assign aw_ready_o = (state_q == SEND_AW) && !rd_sel && flit_ready_i;
  assign ar_ready_o = (state_q == SEND_AW) && rd_sel && flit_ready_i;
  assign w_ready_o  = (state_q == SEND_W) && flit_ready_i;

  assign aw_hs = aw_valid_i && aw_ready_o;
  assign w_hs  = w_valid_i && w_ready_o;
  assign ar_hs = ar_valid_i && ar_ready_o;

  always_comb begin
    state_d = state_q;
    if (aw_hs) begin
      state_d = SEND_W;
    end else if (w_hs && w_i.last) begin
      state_d = SEND_AW;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q   <= SEND_AW;
      hold_q    <= 1'b0;
      rd_sel_q  <= 1'b0;
      rd_prio_q <= 1'b0;
    end else begin
      state_q  <= state_d;
      hold_q   <= flit_valid_o && !flit_ready_i && (state_q == SEND_AW);
      rd_sel_q <= rd_sel;
      if (aw_hs) begin
        rd_prio_q <= 1'b1;
      end else if (ar_hs) begin
        rd_prio_q <= 1'b0;
      end
    end
  end

  // W beats follow the destination of their AW
  always_ff @(posedge clk_i) begin
    if (aw_hs) begin
      aw_dst_q <= aw_dst;
    end
  end

  //////////////////////////////////////////////////
  // Flit assembly
  //////////////////////////////////////////////////

  always_comb begin
    flit_o            = '0;
    flit_o.hdr.src_id = id_i;
    if (state_q == SEND_W) begin
      flit_o.hdr.dst_id = aw_dst_q;
      flit_o.hdr.axi_ch = AXI_W;
      flit_o.hdr.last   = w_i.last;
      flit_o.payload[$bits(axi_w_chan_t)-1:0] = w_i;
    end else if (rd_sel) begin
      flit_o.hdr.dst_id = ar_dst;
      flit_o.hdr.axi_ch = AXI_AR;
      flit_o.hdr.last   = 1'b1;
      flit_o.payload[$bits(axi_ax_chan_t)-1:0] = ar_i;
    end else begin
      flit_o.hdr.dst_id = aw_dst;
      flit_o.hdr.axi_ch = AXI_AW;
      flit_o.hdr.last   = 1'b0;
      flit_o.payload[$bits(axi_ax_chan_t)-1:0] = aw_i;
    end
  end

endmodule

//--- verilog/rsp_flit_unpacker.sv
//////////////////////////////////////////////////
// Response flit unpacker
// Steers B and R flits to the AXI response ports
//////////////////////////////////////////////////

`timescale 1ns/1ns

module rsp_flit_unpacker
  import axi_chan_pkg::*;
  import flit_pkg::*;
(
  input  flit_t       flit_i,
  input  logic        flit_valid_i,
  output logic        flit_ready_o,
  output axi_b_chan_t b_o,
  output logic        b_valid_o,
  input  logic        b_ready_i,
  output axi_r_chan_t r_o,
  output logic        r_valid_o,
  input  logic        r_ready_i
);

  logic is_b, is_r;

  assign is_b = (flit_i.hdr.axi_ch == AXI_B);
  assign is_r = (flit_i.hdr.axi_ch == AXI_R);

  // Payloads sit right-aligned in the flit
  assign b_o = flit_i.payload[$bits(axi_b_chan_t)-1:0];
  assign r_o = flit_i.payload[$bits(axi_r_chan_t)-1:0];

  assign b_valid_o = flit_valid_i && is_b;
  assign r_valid_o = flit_valid_i && is_r;

  always_comb begin
    if (is_b) begin
      flit_ready_o = b_ready_i;
    end else if (is_r) begin
      flit_ready_o = r_ready_i;
    end else begin
      // Any other channel has no sink here and is dropped
      flit_ready_o = 1'b1;
    end
  end

endmodule
